/* project.f */
+incdir+bench
src/predecode_pkg.sv
src/thumb_expander.sv
src/branch_predictor.sv
src/predecode_stage.sv
src/predecode_top.sv
bench/predecode_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the predecode testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module predecode_tb \
        --Mdir obj_dir -o predecode_sim
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/predecode_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
        echo "simulation exited with status $sim_status"
        exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
        exit 0
else
        echo "pass message not found in $LOG"
        exit 1
fi

/* bench/predecode_vectors.svh */
`ifndef PREDECODE_VECTORS_SVH
`define PREDECODE_VECTORS_SVH

// Each row holds name, word, pc, status word, history and {valid, irq, fiq},
// then instruction, {und, irq, fiq, redirect}, target and next history.

localparam logic [31:0] MODE_ARM   = 32'd0;
localparam logic [31:0] MODE_THUMB = 32'd1 << CPSR_T;
localparam logic [31:0] MODE_I     = 32'd1 << CPSR_I;
localparam logic [31:0] MODE_F     = 32'd1 << CPSR_F;
localparam logic [31:0] MODE_IF    = MODE_I | MODE_F;

localparam int NUM_VECTORS = 23;

localparam vector_t VECTORS [NUM_VECTORS] = '{
        '{"mov_lo", 32'hbf00_235a, 32'h0000_1000, MODE_THUMB, BR_WT, 3'b100,
                32'he3b0_305a, 4'b0000, 32'h0000_0000, BR_WT},
        '{"mov_hi", 32'h27ff_0000, 32'h0000_1002, MODE_THUMB, BR_SNT, 3'b100,
                32'he3b0_70ff, 4'b0000, 32'h0000_0000, BR_SNT},
        '{"add_lo", 32'h0000_18a9, 32'h0000_2000, MODE_THUMB, BR_WNT, 3'b100,
                32'he095_1002, 4'b0000, 32'h0000_0000, BR_WNT},
        '{"add_hi", 32'h19c6_e7fe, 32'h0000_2002, MODE_THUMB, BR_SNT, 3'b100,
                32'he090_6007, 4'b0000, 32'h0000_0000, BR_SNT},
        '{"b_lo", 32'h0000_e010, 32'h0000_3000, MODE_THUMB, BR_SNT, 3'b100,
                32'hea00_0010, 4'b0001, 32'h0000_3024, BR_ST},
        '{"b_neg_hi", 32'he7fe_0000, 32'h0000_3002, MODE_THUMB, BR_WNT, 3'b100,
                32'heaff_fffe, 4'b0001, 32'h0000_3002, BR_ST},
        '{"bcond_wt_lo", 32'h0000_d008, 32'h0000_4000, MODE_THUMB, BR_WT, 3'b100,
                32'h0a00_0008, 4'b0001, 32'h0000_4014, BR_WT},
        '{"bcond_wnt_hi", 32'hd1f0_0000, 32'h0000_4002, MODE_THUMB, BR_WNT, 3'b100,
                32'h1aff_fff0, 4'b0000, 32'h0000_0000, BR_WNT},
        '{"bcond_st_neg", 32'h0000_dc80, 32'h0000_5000, MODE_THUMB, BR_ST, 3'b100,
                32'hcaff_ff80, 4'b0001, 32'h0000_4f04, BR_ST},
        '{"swi_und", 32'h0000_df12, 32'h0000_6000, MODE_THUMB, BR_WT, 3'b100,
                32'h0000_0000, 4'b1000, 32'h0000_0000, BR_WT},
        '{"bx_und", 32'h4770_235a, 32'h0000_6002, MODE_THUMB, BR_ST, 3'b100,
                32'h0000_0000, 4'b1000, 32'h0000_0000, BR_ST},
        '{"cond_e_und", 32'h0000_de00, 32'h0000_6100, MODE_THUMB, BR_WNT, 3'b100,
                32'h0000_0000, 4'b1000, 32'h0000_0000, BR_WNT},
        '{"arm_b_al", 32'hea00_0010, 32'h0000_8000, MODE_ARM, BR_SNT, 3'b100,
                32'hea00_0010, 4'b0001, 32'h0000_8048, BR_ST},
        '{"arm_beq_neg", 32'h0aff_fffc, 32'h0000_8100, MODE_ARM, BR_ST, 3'b100,
                32'h0aff_fffc, 4'b0001, 32'h0000_80f8, BR_ST},
        '{"arm_bne_wt", 32'h1a00_0003, 32'h0000_8200, MODE_ARM, BR_WT, 3'b100,
                32'h1a00_0003, 4'b0001, 32'h0000_8214, BR_WT},
        '{"arm_bne_wnt", 32'h1a00_0003, 32'h0000_8300, MODE_ARM, BR_WNT, 3'b100,
                32'h1a00_0003, 4'b0000, 32'h0000_0000, BR_WNT},
        '{"arm_bllt", 32'hbb00_0001, 32'h0000_8400, MODE_ARM, BR_SNT, 3'b100,
                32'hbb00_0001, 4'b0000, 32'h0000_0000, BR_SNT},
        '{"int_open", 32'he1a0_0000, 32'h0000_9000, MODE_ARM, BR_WT, 3'b111,
                32'he1a0_0000, 4'b0110, 32'h0000_0000, BR_WT},
        '{"irq_masked", 32'he1a0_0000, 32'h0000_9004, MODE_I, BR_WT, 3'b111,
                32'he1a0_0000, 4'b0010, 32'h0000_0000, BR_WT},
        '{"fiq_masked", 32'he1a0_0000, 32'h0000_9008, MODE_F, BR_WT, 3'b111,
                32'he1a0_0000, 4'b0100, 32'h0000_0000, BR_WT},
        '{"int_masked", 32'he1a0_0000, 32'h0000_900c, MODE_IF, BR_WT, 3'b111,
                32'he1a0_0000, 4'b0000, 32'h0000_0000, BR_WT},
        '{"int_invalid", 32'hea00_0000, 32'h0000_9010, MODE_ARM, BR_WT, 3'b011,
                32'hea00_0000, 4'b0000, 32'h0000_9018, BR_ST},
        '{"und_invalid", 32'h0000_4770, 32'h0000_9100, MODE_THUMB, BR_SNT, 3'b000,
                32'h0000_0000, 4'b0000, 32'h0000_0000, BR_SNT}
};

`endif

/* bench/predecode_tb.sv */
`default_nettype none

module predecode_tb;

        import predecode_pkg::*;

        localparam int HALF_PERIOD     = 50;
        localparam int RESET_CYCLES    = 5;
        localparam int RESET_TIMEOUT   = 20;
        localparam int WATCHDOG_CYCLES = 2000;
        localparam int NUM_RANDOM      = 8;

        // Reference load for the stall and clear tests.
        localparam logic [31:0] REF_WORD = 32'he1a0_1002;
        localparam logic [31:0] REF_PC   = 32'h0000_a000;

        // One table row with the stimulus first.
        typedef struct packed {
                logic [95:0] name;
                logic [31:0] word;
                logic [31:0] pc;
                logic [31:0] mode;
                logic [1:0]  hist;
                logic [2:0]  flags;
                logic [31:0] exp_instr;
                logic [3:0]  exp_flags;
                logic [31:0] exp_target;
                logic [1:0]  exp_hist;
        } vector_t;

        `include "predecode_vectors.svh"

        logic           i_clk;
        logic           i_reset;
        logic [31:0]    i_instruction;
        logic           i_valid;
        logic [31:0]    i_pc;
        logic [31:0]    i_cpu_mode;
        logic [1:0]     i_taken;
        logic           i_irq;
        logic           i_fiq;
        logic           i_clear_writeback;
        logic           i_stall_data;
        logic           i_clear_alu;
        logic           i_stall_issue;
        predecode_out_t o_out;
        redirect_t      o_redirect;

        int             tests_run;
        int             tests_failed;
        int             test_errors;
        logic [31:0]    lcg_state;

        predecode_top i_dut (
                .i_clk             (i_clk),
                .i_reset           (i_reset),
                .i_instruction     (i_instruction),
                .i_valid           (i_valid),
                .i_pc              (i_pc),
                .i_cpu_mode        (i_cpu_mode),
                .i_taken           (i_taken),
                .i_irq             (i_irq),
                .i_fiq             (i_fiq),
                .i_clear_writeback (i_clear_writeback),
                .i_stall_data      (i_stall_data),
                .i_clear_alu       (i_clear_alu),
                .i_stall_issue     (i_stall_issue),
                .o_out             (o_out),
                .o_redirect        (o_redirect)
        );

        always #HALF_PERIOD i_clk = ~i_clk;

        function automatic logic [31:0] lcg_next(input logic [31:0] state);
                return state * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic compare_value(input string name, input string field,
                                     input logic [31:0] expected, input logic [31:0] actual);
                if (actual !== expected)
                begin
                        $display("error %s: %s expected %h actual %h",
                                 name, field, expected, actual);
                        test_errors++;
                end
        endtask

        task automatic check_outputs(input string name, input logic [31:0] instr,
                                     input logic valid, input logic thumb,
                                     input logic [31:0] pc, input logic irq, input logic fiq,
                                     input logic und, input logic [1:0] hist,
                                     input logic redirect, input logic [31:0] target);
                compare_value(name, "instruction", instr, o_out.instruction);
                compare_value(name, "valid", 32'(valid), 32'(o_out.valid));
                compare_value(name, "thumb", 32'(thumb), 32'(o_out.thumb));
                compare_value(name, "pc", pc, o_out.pc);
                compare_value(name, "irq", 32'(irq), 32'(o_out.irq));
                compare_value(name, "fiq", 32'(fiq), 32'(o_out.fiq));
                compare_value(name, "und", 32'(und), 32'(o_out.und));
                compare_value(name, "history", 32'(hist), 32'(o_out.taken));
                compare_value(name, "redirect", 32'(redirect), 32'(o_redirect.redirect));
                compare_value(name, "target", target, o_redirect.target);
                compare_value(name, "next history", 32'(hist), 32'(o_redirect.taken));
        endtask

        task automatic finish_test(input string name);
                tests_run++;
                if (test_errors == 0)
                        $display("ok   %s", name);
                else
                begin
                        tests_failed++;
                        $display("fail %s", name);
                end
                test_errors = 0;
        endtask

        task automatic drive_inputs(input logic [31:0] word, input logic [31:0] pc,
                                    input logic [31:0] mode, input logic [1:0] hist,
                                    input logic valid, input logic irq, input logic fiq);
                i_instruction = word;
                i_pc          = pc;
                i_cpu_mode    = mode;
                i_taken       = hist;
                i_valid       = valid;
                i_irq         = irq;
                i_fiq         = fiq;
        endtask

        task automatic set_controls(input logic clear_writeback, input logic stall_data,
                                    input logic clear_alu, input logic stall_issue);
                i_clear_writeback = clear_writeback;
                i_stall_data      = stall_data;
                i_clear_alu       = clear_alu;
                i_stall_issue     = stall_issue;
        endtask

        // Loads the reference word and checks it one cycle later.
        task automatic load_reference(input string name);
                set_controls(1'b0, 1'b0, 1'b0, 1'b0);
                drive_inputs(REF_WORD, REF_PC, MODE_ARM, BR_WT, 1'b1, 1'b1, 1'b0);
                @(negedge i_clk);
                check_outputs(name, REF_WORD, 1'b1, 1'b0, REF_PC, 1'b1, 1'b0, 1'b0,
                              BR_WT, 1'b0, 32'd0);
                finish_test(name);
        endtask

        // A taken branch that would show up if the stage loaded.
        task automatic hold_test(input string name);
                drive_inputs(32'hea00_0004, 32'h0000_b000, MODE_ARM, BR_SNT, 1'b1, 1'b0, 1'b0);
                @(negedge i_clk);
                check_outputs(name, REF_WORD, 1'b1, 1'b0, REF_PC, 1'b1, 1'b0, 1'b0,
                              BR_WT, 1'b0, 32'd0);
                finish_test(name);
        endtask

        task automatic clear_test(input string name);
                drive_inputs(32'hea00_0004, 32'h0000_b000, MODE_ARM, BR_SNT, 1'b1, 1'b1, 1'b1);
                @(negedge i_clk);
                check_outputs(name, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
                finish_test(name);
        endtask

        initial
        begin
                #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
                $display("timeout: the simulation did not finish in time");
                $display("STATUS: FAIL");
                $finish;
        end

        initial
        begin
                string       name;
                vector_t     row;
                logic [31:0] word;
                logic [31:0] pc;
                logic [1:0]  hist;
                int          wait_cycles;

                i_clk        = 1'b0;
                i_reset      = 1'b1;
                tests_run    = 0;
                tests_failed = 0;
                test_errors  = 0;
                lcg_state    = 32'hc71b_15e6;
                drive_inputs('0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
                set_controls(1'b0, 1'b0, 1'b0, 1'b0);

                repeat (RESET_CYCLES) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;

                wait_cycles = 0;
                while (o_out.valid !== 1'b0 && wait_cycles < RESET_TIMEOUT)
                begin
                        @(negedge i_clk);
                        wait_cycles++;
                end
                if (o_out.valid !== 1'b0)
                begin
                        $display("timeout: reset did not clear the stage outputs");
                        $display("STATUS: FAIL");
                        $finish;
                end
                compare_value("after_reset", "irq", 32'd0, 32'(o_out.irq));
                compare_value("after_reset", "fiq", 32'd0, 32'(o_out.fiq));
                compare_value("after_reset", "und", 32'd0, 32'(o_out.und));
                compare_value("after_reset", "redirect", 32'd0, 32'(o_redirect.redirect));
                finish_test("after_reset");

                // ARM data-processing words whose class field is never 101.
                for (int n = 0; n < NUM_RANDOM; n++)
                begin
                        lcg_state = lcg_next(lcg_state);
                        word      = {4'he, 2'b00, lcg_state[25:0]};
                        lcg_state = lcg_next(lcg_state);
                        pc        = {lcg_state[31:2], 2'b00};
                        hist      = lcg_state[17:16];
                        drive_inputs(word, pc, MODE_ARM, hist, 1'b1, 1'b0, 1'b0);
                        @(negedge i_clk);
                        name = $sformatf("arm_rand_%0d", n);
                        check_outputs(name, word, 1'b1, 1'b0, pc, 1'b0, 1'b0, 1'b0,
                                      hist, 1'b0, 32'd0);
                        finish_test(name);
                end

                for (int r = 0; r < NUM_VECTORS; r++)
                begin
                        row = VECTORS[r];
                        drive_inputs(row.word, row.pc, row.mode, row.hist,
                                     row.flags[2], row.flags[1], row.flags[0]);
                        @(negedge i_clk);
                        name = $sformatf("%0s", row.name);
                        check_outputs(name, row.exp_instr, row.flags[2], row.mode[CPSR_T],
                                      row.pc, row.exp_flags[2], row.exp_flags[1],
                                      row.exp_flags[3], row.exp_hist, row.exp_flags[0],
                                      row.exp_target);
                        finish_test(name);
                end

                load_reference("load_ref");
                set_controls(1'b0, 1'b1, 1'b0, 1'b0);
                hold_test("stall_data");
                set_controls(1'b0, 1'b0, 1'b0, 1'b1);
                hold_test("stall_issue");
                set_controls(1'b0, 1'b1, 1'b1, 1'b0);
                hold_test("stall_over_alu");
                set_controls(1'b0, 1'b0, 1'b1, 1'b0);
                clear_test("clear_alu");
                load_reference("reload_ref");
                set_controls(1'b1, 1'b1, 1'b0, 1'b0);
                clear_test("clear_over_stall");
                set_controls(1'b0, 1'b0, 1'b0, 1'b0);

                $display("tests run %0d, failed %0d", tests_run, tests_failed);
                if (tests_failed == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

/* src/predecode_top.sv */
`default_nettype none

module predecode_top (
        input  wire                           i_clk,
        input  wire                           i_reset,
        input  wire [31:0]                    i_instruction,
        input  wire                           i_valid,
        input  wire [31:0]                    i_pc,
        input  wire [31:0]                    i_cpu_mode,
        input  wire [1:0]                     i_taken,
        input  wire                           i_irq,
        input  wire                           i_fiq,
        input  wire                           i_clear_writeback,
        input  wire                           i_stall_data,
        input  wire                           i_clear_alu,
        input  wire                           i_stall_issue,
        output predecode_pkg::predecode_out_t o_out,
        output predecode_pkg::redirect_t      o_redirect
);

        import predecode_pkg::*;

        instr_word_u fetch_word;
        expand_t     expand;
        redirect_t   redirect;

        assign fetch_word = i_instruction;

        // Expansion and prediction run side by side.
        thumb_expander u_thumb_expander (
                .i_word     (fetch_word),
                .i_cpu_mode (i_cpu_mode),
                .i_pc       (i_pc),
                .o_expand   (expand)
        );

        branch_predictor u_branch_predictor (
                .i_word     (fetch_word),
                .i_cpu_mode (i_cpu_mode),
                .i_pc       (i_pc),
                .i_taken    (i_taken),
                .o_redirect (redirect)
        );

        predecode_stage u_predecode_stage (
                .i_clk             (i_clk),
                .i_reset           (i_reset),
                .i_valid           (i_valid),
                .i_irq             (i_irq),
                .i_fiq             (i_fiq),
                .i_cpu_mode        (i_cpu_mode),
                .i_pc              (i_pc),
                .i_expand          (expand),
                .i_redirect        (redirect),
                .i_clear_writeback (i_clear_writeback),
                .i_stall_data      (i_stall_data),
                .i_clear_alu       (i_clear_alu),
                .i_stall_issue     (i_stall_issue),
                .o_out             (o_out),
                .o_redirect        (o_redirect)
        );

endmodule

`default_nettype wire

/* src/predecode_stage.sv */
`default_nettype none

module predecode_stage (
        input  wire                              i_clk,
        input  wire                              i_reset,
        input  wire                              i_valid,
        input  wire                              i_irq,
        input  wire                              i_fiq,
        input  wire [31:0]                       i_cpu_mode,
        input  wire [31:0]                       i_pc,
        input  wire predecode_pkg::expand_t      i_expand,
        input  wire predecode_pkg::redirect_t    i_redirect,
        input  wire                              i_clear_writeback,
        input  wire                              i_stall_data,
        input  wire                              i_clear_alu,
        input  wire                              i_stall_issue,
        output predecode_pkg::predecode_out_t    o_out,
        output predecode_pkg::redirect_t         o_redirect
);

        import predecode_pkg::*;

        logic           stage_clear;
        logic           stage_load;
        logic           thumb;
        predecode_out_t out_nxt;
        redirect_t      redirect_nxt;

        assign thumb = i_cpu_mode[CPSR_T];

        // Clear and stall sources in order of priority.
        always_comb
        begin
                stage_clear = 1'b0;
                stage_load  = 1'b0;

                if (i_clear_writeback)
                        stage_clear = 1'b1;
                else if (i_stall_data)
                        stage_load = 1'b0;
                else if (i_clear_alu)
                        stage_clear = 1'b1;
                else if (i_stall_issue)
                        stage_load = 1'b0;
                else
                        stage_load = 1'b1;
        end

        // Merge expander and predictor results.
        always_comb
        begin
                out_nxt.instruction = i_expand.word;
                out_nxt.valid       = i_valid;
                out_nxt.thumb       = thumb;
                out_nxt.pc          = i_pc;

                // Masked interrupts do not enter the pipe.
                out_nxt.irq         = i_valid && i_irq && !i_cpu_mode[CPSR_I];
                out_nxt.fiq         = i_valid && i_fiq && !i_cpu_mode[CPSR_F];

                out_nxt.und         = i_valid && thumb && i_expand.und;
                out_nxt.taken       = i_redirect.taken;

                redirect_nxt          = i_redirect;
                redirect_nxt.redirect = i_valid && i_redirect.redirect;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || stage_clear)
                begin
                        o_out      <= '0;
                        o_redirect <= '0;
                end
                else if (stage_load)
                begin
                        o_out      <= out_nxt;
                        o_redirect <= redirect_nxt;
                end
        end

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
`default_nettype none

module branch_predictor (
        input  wire predecode_pkg::instr_word_u i_word,
        input  wire [31:0]                      i_cpu_mode,
        input  wire [31:0]                      i_pc,
        input  wire [1:0]                       i_taken,
        output predecode_pkg::redirect_t        o_redirect
);

        import predecode_pkg::*;

        logic        thumb;
        logic [15:0] half;
        logic        is_branch;
        logic [3:0]  cond;
        logic [31:0] offset;
        logic [31:0] base;
        logic        history_taken;
        logic        take;

        assign thumb = i_cpu_mode[CPSR_T];
        assign half  = i_pc[1] ? i_word.thumb.upper : i_word.thumb.lower;

        // Branch recognition and offset scaling per state.
        always_comb
        begin
                is_branch = 1'b0;
                cond      = COND_AL;
                offset    = '0;

                if (thumb)
                begin
                        base = i_pc + 32'd4;
                        if (half[15:11] == 5'b11100)
                        begin
                                is_branch = 1'b1;
                                offset    = {{20{half[10]}}, half[10:0], 1'b0};
                        end
                        else if (half[15:12] == 4'b1101 && half[11:9] != 3'b111)
                        begin
                                is_branch = 1'b1;
                                cond      = half[11:8];
                                offset    = {{23{half[7]}}, half[7:0], 1'b0};
                        end
                end
                else
                begin
                        base      = i_pc + 32'd8;
                        is_branch = (i_word.arm.op_class == 3'b101);
                        cond      = i_word.arm.cond;
                        offset    = {{6{i_word.arm.offset[23]}}, i_word.arm.offset, 2'b00};
                end
        end

        always_comb
        begin
                case (i_taken)
                BR_SNT, BR_WNT: history_taken = 1'b0;
                BR_WT, BR_ST:   history_taken = 1'b1;
                default:        history_taken = 1'b0;
                endcase
        end

        assign take = is_branch && (history_taken || cond == COND_AL);

        always_comb
        begin
                o_redirect.redirect = take;
                o_redirect.target   = take ? base + offset : 32'd0;

                // Unconditional branches saturate to strongly taken.
                if (is_branch && cond == COND_AL)
                        o_redirect.taken = BR_ST;
                else
                        o_redirect.taken = i_taken;
        end

endmodule

`default_nettype wire

/* src/thumb_expander.sv */
`default_nettype none

module thumb_expander (
        input  wire predecode_pkg::instr_word_u i_word,
        input  wire [31:0]                      i_cpu_mode,
        input  wire [31:0]                      i_pc,
        output predecode_pkg::expand_t          o_expand
);

        import predecode_pkg::*;

        logic        thumb;
        logic [15:0] half;
        instr_word_u branch_word;
        logic [31:0] alu_word;

        assign thumb = i_cpu_mode[CPSR_T];

        // Upper halfword sits at pc bit 1 set.
        assign half = i_pc[1] ? i_word.thumb.upper : i_word.thumb.lower;

        always_comb
        begin
                branch_word = '0;
                alu_word    = '0;
                o_expand    = '0;

                if (!thumb)
                begin
                        // Nothing to expand in ARM state.
                        o_expand.word = i_word;
                        o_expand.und  = 1'b0;
                end
                else
                begin
                        casez (half)
                        16'b1110_0???_????_????:
                        begin
                                // Unconditional B with an 11-bit offset.
                                branch_word.arm.cond     = COND_AL;
                                branch_word.arm.op_class = 3'b101;
                                branch_word.arm.link     = 1'b0;
                                branch_word.arm.offset   = {{13{half[10]}}, half[10:0]};
                                o_expand.word            = branch_word;
                        end
                        16'b1101_111?_????_????:
                        begin
                                // Undefined and SWI encodings share this space.
                                o_expand.und = 1'b1;
                        end
                        16'b1101_????_????_????:
                        begin
                                // Conditional B with an 8-bit offset.
                                branch_word.arm.cond     = half[11:8];
                                branch_word.arm.op_class = 3'b101;
                                branch_word.arm.link     = 1'b0;
                                branch_word.arm.offset   = {{16{half[7]}}, half[7:0]};
                                o_expand.word            = branch_word;
                        end
                        16'b0010_0???_????_????:
                        begin
                                // MOVS Rd, #imm8.
                                alu_word        = 32'he3b0_0000;
                                alu_word[14:12] = half[10:8];
                                alu_word[7:0]   = half[7:0];
                                o_expand.word   = alu_word;
                        end
                        16'b0001_100?_????_????:
                        begin
                                // ADDS Rd, Rn, Rm.
                                alu_word        = 32'he090_0000;
                                alu_word[18:16] = half[5:3];
                                alu_word[14:12] = half[2:0];
                                alu_word[2:0]   = half[8:6];
                                o_expand.word   = alu_word;
                        end
                        default:
                        begin
                                // Format not supported.
                                o_expand.und = 1'b1;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

/* src/predecode_pkg.sv */
`default_nettype none

package predecode_pkg;

        // Condition code for always-executed instructions.
        localparam logic [3:0] COND_AL = 4'b1110;

        // Bit positions in the status word.
        localparam int CPSR_T = 5;
        localparam int CPSR_F = 6;
        localparam int CPSR_I = 7;

        // Saturating branch history states.
        localparam logic [1:0] BR_SNT = 2'd0;
        localparam logic [1:0] BR_WNT = 2'd1;
        localparam logic [1:0] BR_WT  = 2'd2;
        localparam logic [1:0] BR_ST  = 2'd3;

        // ARM branch layout of a 32-bit word.
        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  op_class;
                logic        link;
                logic [23:0] offset;
        } arm_view_t;

        // Two Thumb halfwords packed into one fetched word.
        typedef struct packed {
                logic [15:0] upper;
                logic [15:0] lower;
        } thumb_view_t;

        // One fetched word, read either as ARM or as two Thumb halfwords.
        typedef union packed {
                arm_view_t   arm;
                thumb_view_t thumb;
        } instr_word_u;

        // Expander result.
        typedef struct packed {
                logic [31:0] word;
                logic        und;
        } expand_t;

        // Predictor result.
        typedef struct packed {
                logic        redirect;
                logic [31:0] target;
                logic [1:0]  taken;
        } redirect_t;

        // Registered stage result.
        typedef struct packed {
                logic [31:0] instruction;
                logic        valid;
                logic        thumb;
                logic [31:0] pc;
                logic        irq;
                logic        fiq;
                logic        und;
                logic [1:0]  taken;
        } predecode_out_t;

endpackage

`default_nettype wire
